// File: hdl/agen_pkg.sv
`default_nettype none

package agen_pkg;

   localparam int ADDR_W     = 10;
   localparam int PERIOD_W   = 10;
   localparam int DELAY_W    = 7;
   localparam int DATA_W     = 32;
   localparam int OFFSET_W   = 2;   // byte offset inside one word.
   localparam int MEM_WORDS  = 256;
   localparam int FIFO_DEPTH = 4;   // also the initial credit count.
   localparam int CREDIT_W   = 3;

   // burst configuration, latched by the generator at run.
   typedef struct packed {
      logic        [PERIOD_W-1:0] period;      // addresses per iteration.
      logic        [PERIOD_W-1:0] duty;        // steps that add incr.
      logic        [ADDR_W-1:0]   iterations;
      logic        [ADDR_W-1:0]   start;       // first byte address.
      logic signed [ADDR_W-1:0]   shift;       // step between periods, in words.
      logic signed [ADDR_W-1:0]   incr;        // step within a period, in words.
      logic        [DELAY_W-1:0]  delay;
   } agen_cfg_t;

   // one buffer entry.
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              last;
   } addr_item_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DELAY,
      ST_RUN
   } agen_state_t;

endpackage

`default_nettype wire

// File: hdl/addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen (
   input  wire logic                clk_i,
   input  wire logic                rst_i,
   input  wire logic                run_i,
   input  wire agen_pkg::agen_cfg_t cfg_i,
   input  wire logic                credit_i,
   output logic                     push_o,
   output agen_pkg::addr_item_t     item_o,
   output logic                     done_o
);
   import agen_pkg::*;

   agen_state_t         state;
   agen_cfg_t           cfg_q;
   logic [DELAY_W-1:0]  delay_cnt;
   logic [PERIOD_W-1:0] per_cnt;    // step index within the period.
   logic [ADDR_W-1:0]   iter_cnt;
   logic [ADDR_W-1:0]   addr_q;
   logic [CREDIT_W-1:0] credits;

   logic                per_end;
   logic                iter_end;
   logic                last_addr;
   logic [ADDR_W-1:0]   incr_step;
   logic [ADDR_W-1:0]   shift_step;
   logic [ADDR_W-1:0]   addr_nxt;

   // compare one bit wider so that the +1 cannot wrap.
   assign per_end   = ({1'b0, per_cnt} + 1'b1) >= {1'b0, cfg_q.period};
   assign iter_end  = ({1'b0, iter_cnt} + 1'b1) >= {1'b0, cfg_q.iterations};
   assign last_addr = per_end && iter_end;

   // word steps scaled to bytes, wrapping modulo 2**ADDR_W.
   assign incr_step  = cfg_q.incr << OFFSET_W;
   assign shift_step = cfg_q.shift << OFFSET_W;

   always_comb begin
      addr_nxt = addr_q;
      if (per_end) begin
         addr_nxt = addr_q + shift_step;
      end else if (per_cnt < cfg_q.duty) begin
         addr_nxt = addr_q + incr_step;
      end
   end

   assign push_o      = (state == ST_RUN) && (credits != '0);
   assign item_o.addr = addr_q;
   assign item_o.last = last_addr;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state     <= ST_IDLE;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         done_o    <= 1'b1;
      end else begin
         case (state)
            ST_IDLE: begin
               if (run_i) begin
                  done_o    <= 1'b0;
                  per_cnt   <= '0;
                  iter_cnt  <= '0;
                  delay_cnt <= cfg_i.delay;
                  if (cfg_i.delay == '0) begin
                     state <= ST_RUN;
                  end else begin
                     state <= ST_DELAY;
                  end
               end
            end
            ST_DELAY: begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == DELAY_W'(1)) begin
                  state <= ST_RUN;
               end
            end
            ST_RUN: begin
               if (push_o) begin
                  if (last_addr) begin
                     state  <= ST_IDLE;
                     done_o <= 1'b1;
                  end else if (per_end) begin
                     per_cnt  <= '0;
                     iter_cnt <= iter_cnt + 1'b1;
                  end else begin
                     per_cnt <= per_cnt + 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state == ST_IDLE) && run_i) begin
         cfg_q  <= cfg_i;
         addr_q <= cfg_i.start;
      end else if (push_o) begin
         addr_q <= addr_nxt;  // position survives a stall.
      end
   end

   // one credit per free buffer entry.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         credits <= CREDIT_W'(FIFO_DEPTH);
      end else begin
         case ({push_o, credit_i})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // returned credits must never outnumber the buffer entries.
   a_credit_max: assert property (@(posedge clk_i) disable iff (rst_i)
      credits <= CREDIT_W'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: hdl/addr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module addr_fifo (
   input  wire logic                 clk_i,
   input  wire logic                 rst_i,
   input  wire logic                 push_i,
   input  wire agen_pkg::addr_item_t item_i,
   input  wire logic                 pop_i,
   output logic                      head_valid_o,
   output agen_pkg::addr_item_t      head_item_o,
   output logic                      credit_o
);
   import agen_pkg::*;

   addr_item_t                    mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
   logic [CREDIT_W-1:0]           count;   // 0 to FIFO_DEPTH.

   assign head_valid_o = (count != '0);
   assign head_item_o  = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_ptr] <= item_i;
      end
   end

   // pointers wrap on their own, depth is a power of two.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         count <= '0;
      end else begin
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // the freed entry goes back to the producer one cycle later.
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         credit_o <= 1'b0;
      end else begin
         credit_o <= pop_i;
      end
   end

   // the producer's credit count must keep the queue from overflowing.
   a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
      push_i |-> (count != CREDIT_W'(FIFO_DEPTH)));

   a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> (count != '0));

endmodule

`default_nettype wire

// File: hdl/mem_reader.sv
`timescale 1ns/1ps
`default_nettype none

module mem_reader (
   input  wire logic                                    clk_i,
   input  wire logic                                    rst_i,
   input  wire logic                                    head_valid_i,
   input  wire agen_pkg::addr_item_t                    head_item_i,
   input  wire logic                                    wr_en_i,
   input  wire logic [$clog2(agen_pkg::MEM_WORDS)-1:0]  wr_addr_i,
   input  wire logic [agen_pkg::DATA_W-1:0]             wr_data_i,
   input  wire logic                                    ready_i,
   output logic                                         pop_o,
   output logic                                         valid_o,
   output logic [agen_pkg::DATA_W-1:0]                  data_o,
   output logic                                         last_o
);
   import agen_pkg::*;

   logic [DATA_W-1:0]              mem [MEM_WORDS];
   logic [$clog2(MEM_WORDS)-1:0]   rd_word;

   // word index, byte offset dropped.
   assign rd_word = head_item_i.addr[ADDR_W-1:OFFSET_W];

   // take a new entry when the output register is free or empties now.
   assign pop_o = head_valid_i && (!valid_o || ready_i);

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         data_o <= mem[rd_word];
         last_o <= head_item_i.last;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_o <= 1'b0;
      end else if (pop_o) begin
         valid_o <= 1'b1;
      end else if (ready_i) begin
         valid_o <= 1'b0;  // drained, nothing new behind it.
      end
   end

   // a stalled word must not change under the sink.
   a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (valid_o && !ready_i) |=> (valid_o && $stable(data_o) && $stable(last_o)));

endmodule

`default_nettype wire

// File: hdl/stride_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

module stride_engine_top (
   input  wire logic                                    clk_i,
   input  wire logic                                    rst_i,
   input  wire logic                                    run_i,
   input  wire agen_pkg::agen_cfg_t                     cfg_i,
   input  wire logic                                    wr_en_i,
   input  wire logic [$clog2(agen_pkg::MEM_WORDS)-1:0]  wr_addr_i,
   input  wire logic [agen_pkg::DATA_W-1:0]             wr_data_i,
   input  wire logic                                    ready_i,
   output logic                                         valid_o,
   output logic [agen_pkg::DATA_W-1:0]                  data_o,
   output logic                                         last_o,
   output logic                                         done_o
);
   import agen_pkg::*;

   logic       push;
   addr_item_t push_item;
   logic       credit;     // closes the loop back to the generator.
   logic       head_valid;
   addr_item_t head_item;
   logic       pop;

   addr_gen u_gen (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .run_i    (run_i),
      .cfg_i    (cfg_i),
      .credit_i (credit),
      .push_o   (push),
      .item_o   (push_item),
      .done_o   (done_o)
   );

   addr_fifo u_fifo (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .push_i       (push),
      .item_i       (push_item),
      .pop_i        (pop),
      .head_valid_o (head_valid),
      .head_item_o  (head_item),
      .credit_o     (credit)
   );

   mem_reader u_rd (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .head_valid_i (head_valid),
      .head_item_i  (head_item),
      .wr_en_i      (wr_en_i),
      .wr_addr_i    (wr_addr_i),
      .wr_data_i    (wr_data_i),
      .ready_i      (ready_i),
      .pop_o        (pop),
      .valid_o      (valid_o),
      .data_o       (data_o),
      .last_o       (last_o)
   );

endmodule

`default_nettype wire

// File: sim/tb_stride_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stride_engine;
   import agen_pkg::*;

   localparam int N_TESTS = 6;

   logic              clk_i = 1'b0;
   logic              rst_i;
   logic              run_i;
   agen_cfg_t         cfg_i;
   logic              wr_en_i;
   logic [7:0]        wr_addr_i;
   logic [DATA_W-1:0] wr_data_i;
   logic              ready_i;
   logic              valid_o;
   logic [DATA_W-1:0] data_o;
   logic              last_o;
   logic              done_o;

   // test table.
   string     tbl_name  [N_TESTS];
   agen_cfg_t tbl_cfg   [N_TESTS];
   bit        tbl_rand  [N_TESTS];   // ready drawn from $random when set.
   int        tbl_count [N_TESTS];

   logic [DATA_W-1:0] mem_copy [MEM_WORDS];
   int                exp_addr [0:511];
   int                exp_len;
   integer            seed;
   int                err_cnt;
   int                pass_cnt;
   int                fail_cnt;
   int                cycle_cnt;
   int                timeout_limit;
   logic              timing_on;

   stride_engine_top u_dut (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .run_i     (run_i),
      .cfg_i     (cfg_i),
      .wr_en_i   (wr_en_i),
      .wr_addr_i (wr_addr_i),
      .wr_data_i (wr_data_i),
      .ready_i   (ready_i),
      .valid_o   (valid_o),
      .data_o    (data_o),
      .last_o    (last_o),
      .done_o    (done_o)
   );

   always #20 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      if (timing_on) begin
         cycle_cnt <= cycle_cnt + 1;
         if (cycle_cnt >= timeout_limit) begin
            $display("timeout: the run exceeded %0d cycles", timeout_limit);
            $display("sim failed");
            $finish;
         end
      end
   end

   function automatic agen_cfg_t make_cfg(input int period, input int duty, input int iter,
                                          input int start, input int shift, input int incr,
                                          input int delay);
      agen_cfg_t c;
      c.period     = PERIOD_W'(period);
      c.duty       = PERIOD_W'(duty);
      c.iterations = ADDR_W'(iter);
      c.start      = ADDR_W'(start);
      c.shift      = ADDR_W'(shift);
      c.incr       = ADDR_W'(incr);
      c.delay      = DELAY_W'(delay);
      return c;
   endfunction

   task automatic set_row(input int r, input string name, input bit rand_ready,
                          input int count, input agen_cfg_t cfg);
      tbl_name[r]  = name;
      tbl_rand[r]  = rand_ready;
      tbl_count[r] = count;
      tbl_cfg[r]   = cfg;
   endtask

   // reference address sequence, worked out in plain integers.
   task automatic build_addr_list(input agen_cfg_t c);
      int a;
      int inc;
      int sh;
      int mask;
      mask    = (1 << ADDR_W) - 1;
      a       = int'(c.start);
      inc     = int'($signed(c.incr));
      sh      = int'($signed(c.shift));
      exp_len = 0;
      for (int it = 0; it < int'(c.iterations); it++) begin
         for (int s = 0; s < int'(c.period); s++) begin
            exp_addr[exp_len] = a;
            exp_len++;
            if (s + 1 == int'(c.period)) begin
               if (it != int'(c.iterations) - 1) a = (a + 4 * sh) & mask;
            end else if (s < int'(c.duty)) begin
               a = (a + 4 * inc) & mask;
            end
         end
      end
   endtask

   task automatic report(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         $display("test %s: ok", name);
         pass_cnt++;
      end else begin
         $display("test %s: FAILED with %0d errors", name, err_cnt - errs_before);
         fail_cnt++;
      end
   endtask

   task automatic run_test(input int r);
      agen_cfg_t         cfg;
      logic [DATA_W-1:0] exp_word;
      int                got;
      int                k;
      int                first_valid;
      int                errs_before;
      bit                early_done;
      cfg         = tbl_cfg[r];
      errs_before = err_cnt;
      got         = 0;
      first_valid = -1;
      early_done  = 1'b0;
      build_addr_list(cfg);
      @(posedge clk_i);
      if (done_o !== 1'b1) begin
         $display("test %s: done_o is low before the run", tbl_name[r]);
         err_cnt++;
      end
      cfg_i   <= cfg;
      run_i   <= 1'b1;
      ready_i <= tbl_rand[r] ? 1'($random(seed)) : 1'b1;
      @(posedge clk_i);
      run_i   <= 1'b0;
      ready_i <= tbl_rand[r] ? 1'($random(seed)) : 1'b1;
      k = 0;
      while (got < exp_len) begin
         @(posedge clk_i);
         k++;
         if (valid_o === 1'b1 && first_valid < 0) first_valid = k;
         if (valid_o === 1'b1 && ready_i === 1'b1) begin
            exp_word = mem_copy[exp_addr[got] >> OFFSET_W];
            if (data_o !== exp_word) begin
               $display("mismatch test=%s item=%0d expected=%h actual=%h",
                        tbl_name[r], got, exp_word, data_o);
               err_cnt++;
            end
            if (got == exp_len - 1) begin
               if (last_o !== 1'b1) begin
                  $display("test %s: last_o missing on the final word", tbl_name[r]);
                  err_cnt++;
               end
               if (done_o !== 1'b1) begin
                  $display("test %s: done_o low at the final word", tbl_name[r]);
                  err_cnt++;
               end
            end else if (last_o === 1'b1) begin
               $display("test %s: last_o high on word %0d of %0d", tbl_name[r], got, exp_len);
               err_cnt++;
            end
            got++;
         end
         // at most four buffered addresses and one output word trail the last push.
         if (done_o === 1'b1 && (exp_len - got) > FIFO_DEPTH + 1 && !early_done) begin
            $display("test %s: done_o high with %0d words still to come",
                     tbl_name[r], exp_len - got);
            early_done = 1'b1;
            err_cnt++;
         end
         ready_i <= tbl_rand[r] ? 1'($random(seed)) : 1'b1;
      end
      if (first_valid < int'(cfg.delay) + 3) begin
         $display("test %s: valid_o rose %0d cycles after run, delay is %0d",
                  tbl_name[r], first_valid, cfg.delay);
         err_cnt++;
      end
      repeat (3) begin
         @(posedge clk_i);
         if (valid_o === 1'b1 && ready_i === 1'b1) begin
            got++;
         end
         if (valid_o !== 1'b0) begin
            $display("test %s: extra word after the final transfer", tbl_name[r]);
            err_cnt++;
         end
         if (done_o !== 1'b1) begin
            $display("test %s: done_o dropped before the next run", tbl_name[r]);
            err_cnt++;
         end
         ready_i <= 1'b1;
      end
      if (got != tbl_count[r]) begin
         $display("mismatch test=%s count expected=%0d actual=%0d",
                  tbl_name[r], tbl_count[r], got);
         err_cnt++;
      end
      report(tbl_name[r], errs_before);
   endtask

   initial begin
      rst_i     = 1'b1;
      run_i     = 1'b0;
      cfg_i     = '0;
      wr_en_i   = 1'b0;
      wr_addr_i = '0;
      wr_data_i = '0;
      ready_i   = 1'b0;
      timing_on = 1'b0;
      cycle_cnt = 0;
      seed      = 16301;
      err_cnt   = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;

      set_row(0, "contiguous", 1'b0, 8, make_cfg(8, 8, 1, 'h010, 0, 1, 0));
      set_row(1, "neg_incr_wrap", 1'b0, 12, make_cfg(4, 2, 3, 'h3F8, 3, -1, 0));
      set_row(2, "neg_shift", 1'b0, 15, make_cfg(5, 3, 3, 'h008, -12, 2, 0));
      set_row(3, "start_delay", 1'b0, 12, make_cfg(6, 6, 2, 'h100, -1, 3, 25));
      set_row(4, "backpressure", 1'b1, 32, make_cfg(16, 16, 2, 'h200, 2, 1, 3));
      set_row(5, "bp_strided", 1'b1, 15, make_cfg(3, 1, 5, 'h3FC, 7, -3, 0));

      timeout_limit = 0;
      for (int r = 0; r < N_TESTS; r++) begin
         timeout_limit += int'(tbl_cfg[r].delay) + 10 * tbl_count[r] + 20;
      end

      repeat (5) @(posedge clk_i);
      rst_i <= 1'b0;
      @(posedge clk_i);
      if (valid_o !== 1'b0 || done_o !== 1'b1) begin
         $display("mismatch test=reset_state expected=valid_o 0 done_o 1 actual=valid_o %b done_o %b",
                  valid_o, done_o);
         err_cnt++;
      end
      report("reset_state", 0);

      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_copy[i] = $random(seed);
         @(posedge clk_i);
         wr_en_i   <= 1'b1;
         wr_addr_i <= 8'(i);
         wr_data_i <= mem_copy[i];
      end
      @(posedge clk_i);
      wr_en_i   <= 1'b0;
      timing_on <= 1'b1;

      for (int r = 0; r < N_TESTS; r++) begin
         run_test(r);
      end

      $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: stride_engine_top.f
hdl/agen_pkg.sv
hdl/addr_gen.sv
hdl/addr_fifo.sv
hdl/mem_reader.sv
hdl/stride_engine_top.sv
sim/tb_stride_engine.sv

// File: Bender.yml
package:
  name: stride_engine

sources:
  - hdl/agen_pkg.sv
  - hdl/addr_gen.sv
  - hdl/addr_fifo.sv
  - hdl/mem_reader.sv
  - hdl/stride_engine_top.sv
  - target: simulation
    files:
      - sim/tb_stride_engine.sv
